/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       := tb_l2_tlb
FILELIST  := tb.f
OBJ_DIR   := obj_dir

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* hdl/l2_tlb.sv */
////////////////////////////////////////
// L2 TLB lookup engine, top level
// waddr_i is a word address, top bit set for the PA table
// req_i must stay stable until the response handshake
////////////////////////////////////////
module l2_tlb
   import tlb_cfg_pkg::*, tlb_types_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_ni,
   input  logic                  we_i,
   input  cfg_addr_t             waddr_i,
   input  logic [CFG_DATA_W-1:0] wdata_i,
   input  logic                  start_i,
   input  lookup_req_t           req_i,
   input  logic                  out_ready_i,
   output logic                  busy_o,
   output logic                  out_valid_o,
   output tlb_resp_t             resp_o
);

   logic [N_PAR_VA_RAMS-1:0] bank_we;
   logic                     pa_we;
   bank_idx_t                bank_sel;
   entry_addr_t              entry_waddr;
   va_entry_t                entry_wdata;
   va_result_t               results [N_PAR_VA_RAMS];
   logic                     rd_en;
   offset_t                  rd_offset;
   logic                     search_done;
   logic                     resp_done;
   hit_sel_t                 sel;

   ////////////////////////////////////////
   // Write address decode
   ////////////////////////////////////////
   assign bank_sel    = waddr_i[LL_W-1:0];
   assign entry_waddr = waddr_i[LL_W +: ENTRY_ADDR_W];
   assign entry_wdata = va_entry_t'(wdata_i[$bits(va_entry_t)-1:0]);
   assign pa_we       = we_i && waddr_i[CFG_ADDR_W-1];

   always_comb begin
      for (int b = 0; b < N_PAR_VA_RAMS; b++) begin
         bank_we[b] = we_i && !waddr_i[CFG_ADDR_W-1] && (bank_sel == bank_idx_t'(b));
      end
   end

   for (genvar g = 0; g < N_PAR_VA_RAMS; g++) begin : g_va_bank
      va_check_ram u_va_check_ram (
         .clk_i       (clk_i),
         .rst_ni      (rst_ni),
         .we_i        (bank_we[g]),
         .waddr_i     (entry_waddr),
         .wdata_i     (entry_wdata),
         .req_i       (req_i),
         .rd_en_i     (rd_en),
         .rd_offset_i (rd_offset),
         .result_o    (results[g])
      );
   end

   tlb_search_ctrl u_search_ctrl (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .start_i     (start_i),
      .va_write_i  (|bank_we),   // Any bank write pauses the search
      .results_i   (results),
      .resp_done_i (resp_done),
      .busy_o      (busy_o),
      .rd_en_o     (rd_en),
      .rd_offset_o (rd_offset),
      .done_o      (search_done),
      .sel_o       (sel)
   );

   tlb_resp_ctrl u_resp_ctrl (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .done_i      (search_done),
      .sel_i       (sel),
      .pa_we_i     (pa_we),
      .pa_waddr_i  (waddr_i[PA_ADDR_W-1:0]),
      .pa_wdata_i  (wdata_i[PPN_W-1:0]),
      .page_off_i  (req_i.vaddr[PAGE_LSB-1:0]),
      .out_ready_i (out_ready_i),
      .out_valid_o (out_valid_o),
      .resp_o      (resp_o),
      .resp_done_o (resp_done)
   );

endmodule

/* hdl/tlb_cfg_pkg.sv */
////////////////////////////////////////
// Table geometry of the L2 TLB
// N_SETS, N_OFFSETS and N_PAR_VA_RAMS must be powers of two
// N_PAR_VA_RAMS must be at least 2, since the bank select field is LL_W bits wide
// Pages are 2**PAGE_LSB bytes
////////////////////////////////////////
package tlb_cfg_pkg;

   localparam int VADDR_W       = 32;
   localparam int PADDR_W       = 40;
   localparam int PAGE_LSB      = 12;
   localparam int N_SETS        = 8;
   localparam int N_OFFSETS     = 4;   // Per group, two groups per set
   localparam int N_PAR_VA_RAMS = 2;
   localparam int CFG_DATA_W    = 64;

   ////////////////////////////////////////
   // Derived widths
   ////////////////////////////////////////
   localparam int SET_W        = $clog2(N_SETS);
   localparam int OFFSET_W     = $clog2(N_OFFSETS);
   localparam int LL_W         = $clog2(N_PAR_VA_RAMS);
   localparam int ENTRY_ADDR_W = SET_W + 1 + OFFSET_W;   // {set, group, offset}
   localparam int PA_ADDR_W    = ENTRY_ADDR_W + LL_W;
   localparam int CFG_ADDR_W   = LL_W + ENTRY_ADDR_W + 1;   // Top bit picks PA table
   localparam int VPN_W        = VADDR_W - PAGE_LSB;
   localparam int PPN_W        = PADDR_W - PAGE_LSB;
   localparam int VA_DEPTH     = 2 * N_SETS * N_OFFSETS;
   localparam int PA_DEPTH     = VA_DEPTH * N_PAR_VA_RAMS;

   typedef logic [VADDR_W-1:0]      vaddr_t;
   typedef logic [PADDR_W-1:0]      paddr_t;
   typedef logic [VPN_W-1:0]        vpn_t;
   typedef logic [PPN_W-1:0]        ppn_t;
   typedef logic [SET_W-1:0]        set_idx_t;
   typedef logic [OFFSET_W-1:0]     offset_t;
   typedef logic [ENTRY_ADDR_W-1:0] entry_addr_t;
   typedef logic [PA_ADDR_W-1:0]    pa_addr_t;
   typedef logic [LL_W-1:0]         bank_idx_t;
   typedef logic [CFG_ADDR_W-1:0]   cfg_addr_t;

   localparam offset_t OFFSET_LAST = offset_t'(N_OFFSETS - 1);   // Final search cycle

endpackage

/* hdl/tlb_resp_ctrl.sv */
////////////////////////////////////////
// PA table and response hold
// PA table is single ported, a write delays the read
// paddr reads as zero on a miss or a fault
////////////////////////////////////////
module tlb_resp_ctrl
   import tlb_cfg_pkg::*, tlb_types_pkg::*;
(
   input  logic                clk_i,
   input  logic                rst_ni,
   input  logic                done_i,
   input  hit_sel_t            sel_i,
   input  logic                pa_we_i,
   input  pa_addr_t            pa_waddr_i,
   input  ppn_t                pa_wdata_i,
   input  logic [PAGE_LSB-1:0] page_off_i,
   input  logic                out_ready_i,
   output logic                out_valid_o,
   output tlb_resp_t           resp_o,
   output logic                resp_done_o
);

   ppn_t        pa_mem [PA_DEPTH];
   resp_state_t state_q, state_d;
   logic        hit_q, miss_q, prot_q, coh_q;
   logic        hit_d, miss_d, prot_d, coh_d;
   pa_addr_t    pa_addr_q;     // Kept for the read after WAIT_ON_WRITE
   pa_addr_t    pa_raddr;
   logic        pa_rd_en;
   ppn_t        ppn_q;

   ////////////////////////////////////////
   // PA table
   ////////////////////////////////////////
   always_ff @(posedge clk_i) begin
      if (pa_we_i) begin
         pa_mem[pa_waddr_i] <= pa_wdata_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (pa_rd_en) begin
         ppn_q <= pa_mem[pa_raddr];
      end
   end

   always_ff @(posedge clk_i) begin
      if (done_i) begin
         pa_addr_q <= sel_i.pa_addr;
      end
   end

   ////////////////////////////////////////
   // Response FSM
   ////////////////////////////////////////
   always_comb begin
      state_d     = state_q;
      hit_d       = hit_q;
      miss_d      = miss_q;
      prot_d      = prot_q;
      coh_d       = coh_q;
      pa_raddr    = sel_i.pa_addr;
      pa_rd_en    = 1'b0;
      out_valid_o = 1'b0;
      resp_done_o = 1'b0;

      unique case (state_q)
         RESP_IDLE: begin
            hit_d  = 1'b0;
            miss_d = 1'b0;
            prot_d = 1'b0;
            coh_d  = 1'b0;
            if (done_i) begin
               hit_d  = sel_i.hit;
               miss_d = !sel_i.hit;
               prot_d = sel_i.prot;
               coh_d  = sel_i.coherent;
               if (sel_i.hit && !sel_i.prot && pa_we_i) begin
                  state_d = WAIT_ON_WRITE;   // Table busy this cycle
               end else begin
                  state_d  = SEND_OUTPUT;
                  pa_rd_en = sel_i.hit && !sel_i.prot;
               end
            end
         end
         WAIT_ON_WRITE: begin
            if (!pa_we_i) begin
               pa_raddr = pa_addr_q;
               pa_rd_en = 1'b1;
               state_d  = SEND_OUTPUT;
            end
         end
         SEND_OUTPUT: begin
            out_valid_o = 1'b1;
            if (out_ready_i) begin
               resp_done_o = 1'b1;
               state_d     = RESP_IDLE;
            end
         end
         default: state_d = RESP_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         state_q <= RESP_IDLE;
         hit_q   <= 1'b0;
         miss_q  <= 1'b0;
         prot_q  <= 1'b0;
         coh_q   <= 1'b0;
      end else begin
         state_q <= state_d;
         hit_q   <= hit_d;
         miss_q  <= miss_d;
         prot_q  <= prot_d;
         coh_q   <= coh_d;
      end
   end

   assign resp_o.hit      = hit_q;
   assign resp_o.miss     = miss_q;
   assign resp_o.prot     = prot_q;
   assign resp_o.coherent = coh_q;
   assign resp_o.paddr    = (hit_q && !prot_q) ? paddr_t'({ppn_q, page_off_i}) : '0;

   // Back-pressure keeps the response frozen
   a_resp_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
      (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(resp_o)));

endmodule

/* hdl/tlb_search_ctrl.sv */
////////////////////////////////////////
// Search FSM over all offsets of a set
// Every search starts at offset 0
// Stops on the first cycle with any match
////////////////////////////////////////
module tlb_search_ctrl
   import tlb_cfg_pkg::*, tlb_types_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_ni,
   input  logic       start_i,
   input  logic       va_write_i,
   input  va_result_t results_i [N_PAR_VA_RAMS],
   input  logic       resp_done_i,
   output logic       busy_o,
   output logic       rd_en_o,
   output offset_t    rd_offset_o,
   output logic       done_o,
   output hit_sel_t   sel_o
);

   search_state_t state_q, state_d;
   offset_t       offset_q;
   offset_t       rd_off_q;      // Offset of the result now at the banks' outputs
   logic          issued_all_q;
   logic          rd_valid_q;
   logic          any_hit, any_prot;
   bank_idx_t     win_bank;

   ////////////////////////////////////////
   // Bank priority
   ////////////////////////////////////////
   always_comb begin
      any_hit  = 1'b0;
      any_prot = 1'b0;
      win_bank = '0;
      // Walk down so the lowest bank with a hit is kept
      for (int i = N_PAR_VA_RAMS - 1; i >= 0; i--) begin
         any_prot = any_prot | results_i[i].prot;
         if (results_i[i].hit) begin
            any_hit  = 1'b1;
            win_bank = bank_idx_t'(i);
         end
      end
   end

   assign sel_o.hit      = any_hit;
   assign sel_o.prot     = any_prot;
   assign sel_o.coherent = any_hit && !any_prot && results_i[win_bank].coherent;
   assign sel_o.pa_addr  = pa_addr_t'(N_PAR_VA_RAMS) * pa_addr_t'(results_i[win_bank].addr)
                         + pa_addr_t'(win_bank);

   // rd_valid_q only follows a read issued in SEARCH
   assign done_o = rd_valid_q && (any_hit || (rd_off_q == OFFSET_LAST));

   // No read while a bank is written, or once the set is covered
   assign rd_en_o     = (state_q == SEARCH) && !va_write_i && !issued_all_q && !done_o;
   assign rd_offset_o = offset_q;
   assign busy_o      = (state_q != IDLE);

   always_comb begin
      state_d = state_q;
      unique case (state_q)
         IDLE: begin
            if (start_i) begin
               state_d = SEARCH;
            end
         end
         SEARCH: begin
            if (done_o) begin
               state_d = DONE;
            end
         end
         DONE: begin
            if (resp_done_i) begin   // Hold busy until the response is taken
               state_d = IDLE;
            end
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         state_q      <= IDLE;
         offset_q     <= '0;
         rd_off_q     <= '0;
         issued_all_q <= 1'b0;
         rd_valid_q   <= 1'b0;
      end else begin
         state_q    <= state_d;
         rd_valid_q <= rd_en_o;   // Bank output valid one cycle later
         if (state_q == IDLE) begin
            offset_q     <= '0;
            issued_all_q <= 1'b0;
         end else if (rd_en_o) begin
            offset_q <= offset_q + 1'b1;
            rd_off_q <= offset_q;
            if (offset_q == OFFSET_LAST) begin
               issued_all_q <= 1'b1;
            end
         end
      end
   end

   a_done_in_search : assert property (@(posedge clk_i) disable iff (!rst_ni)
      done_o |-> (state_q == SEARCH) ##1 (state_q == DONE));

   a_offset_range : assert property (@(posedge clk_i) disable iff (!rst_ni)
      rd_en_o |-> (rd_offset_o <= OFFSET_LAST));

endmodule

/* hdl/tlb_types_pkg.sv */
////////////////////////////////////////
// Entry, request and response formats
// va_entry_t sits in the low bits of a write word
////////////////////////////////////////
package tlb_types_pkg;
   import tlb_cfg_pkg::*;

   // One VA bank entry, 24 bits
   typedef struct packed {
      vpn_t vpn;
      logic coherent;
      logic wr;        // Write allowed
      logic rd;        // Read allowed
      logic valid;
   } va_entry_t;

   typedef struct packed {
      vaddr_t vaddr;
      logic   wr;      // 1 for a write access
   } lookup_req_t;

   // Per bank result of one search cycle
   typedef struct packed {
      logic        hit;
      logic        prot;
      logic        coherent;
      entry_addr_t addr;
   } va_result_t;

   // Winner over all banks
   typedef struct packed {
      logic     hit;
      logic     prot;
      logic     coherent;
      pa_addr_t pa_addr;
   } hit_sel_t;

   typedef struct packed {
      logic   hit;
      logic   miss;
      logic   prot;
      logic   coherent;
      paddr_t paddr;
   } tlb_resp_t;

   typedef enum logic [1:0] {IDLE, SEARCH, DONE} search_state_t;

   typedef enum logic [1:0] {RESP_IDLE, WAIT_ON_WRITE, SEND_OUTPUT} resp_state_t;

endpackage

/* hdl/va_check_ram.sv */
////////////////////////////////////////
// One VA bank, two groups per set
// Port 0 is shared with writes, so reads must pause while we_i is high
// Result appears one cycle after rd_en_i
////////////////////////////////////////
module va_check_ram
   import tlb_cfg_pkg::*, tlb_types_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_ni,
   input  logic        we_i,
   input  entry_addr_t waddr_i,
   input  va_entry_t   wdata_i,
   input  lookup_req_t req_i,
   input  logic        rd_en_i,
   input  offset_t     rd_offset_i,
   output va_result_t  result_o
);

   va_entry_t   mem [VA_DEPTH];
   set_idx_t    set_idx;
   vpn_t        req_vpn;
   entry_addr_t port0_addr, port1_addr;
   va_entry_t   entry0, entry1;
   logic        match0, match1;
   logic        prot0, prot1;

   assign set_idx = req_i.vaddr[PAGE_LSB +: SET_W];
   assign req_vpn = req_i.vaddr[VADDR_W-1:PAGE_LSB];

   // Group 0 on port 0, group 1 on port 1
   assign port0_addr = we_i ? waddr_i : entry_addr_t'({set_idx, 1'b0, rd_offset_i});
   assign port1_addr = entry_addr_t'({set_idx, 1'b1, rd_offset_i});

   always_ff @(posedge clk_i) begin
      if (we_i) begin
         mem[port0_addr] <= wdata_i;
      end
   end

   assign entry0 = mem[port0_addr];
   assign entry1 = mem[port1_addr];

   ////////////////////////////////////////
   // Tag and permission compare
   ////////////////////////////////////////
   assign match0 = entry0.valid && (entry0.vpn == req_vpn);
   assign match1 = entry1.valid && (entry1.vpn == req_vpn);
   assign prot0  = match0 && (req_i.wr ? !entry0.wr : !entry0.rd);
   assign prot1  = match1 && (req_i.wr ? !entry1.wr : !entry1.rd);

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         result_o <= '0;
      end else if (rd_en_i) begin
         result_o.hit  <= match0 || match1;
         result_o.prot <= prot0 || prot1;
         if (match0) begin                        // Group 0 wins
            result_o.coherent <= entry0.coherent;
            result_o.addr     <= port0_addr;
         end else begin
            result_o.coherent <= entry1.coherent;
            result_o.addr     <= port1_addr;
         end
      end
   end

   // The search controller must hold off reads during any bank write
   a_no_rd_during_we : assert property (@(posedge clk_i) disable iff (!rst_ni)
      !(rd_en_i && we_i));

endmodule

/* tb.f */
hdl/tlb_cfg_pkg.sv
hdl/tlb_types_pkg.sv
hdl/va_check_ram.sv
hdl/tlb_search_ctrl.sv
hdl/tlb_resp_ctrl.sv
hdl/l2_tlb.sv
tests/tb_l2_tlb.sv

/* tests/tb_l2_tlb.sv */
////////////////////////////////////////
// Testbench for the L2 TLB lookup engine
// Fills every bank entry and PA word before the lookups
// Noise writes go only to the set after the one searched
////////////////////////////////////////
module tb_l2_tlb
   import tlb_cfg_pkg::*, tlb_types_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD     = 20;
   localparam int N_LOOKUPS      = 24;
   localparam int MAX_READY_WAIT = 7;
   localparam int LOOKUP_CYCLES  = 4 * N_OFFSETS + 16 + MAX_READY_WAIT;   // Noise pauses included
   localparam int SETUP_CYCLES   = 2 * (N_PAR_VA_RAMS * VA_DEPTH + PA_DEPTH) + 40;

   logic                  clk_i, rst_ni, we_i, start_i, out_ready_i;
   cfg_addr_t             waddr_i;
   logic [CFG_DATA_W-1:0] wdata_i;
   lookup_req_t           req_i;
   logic                  busy_o, out_valid_o;
   tlb_resp_t             resp_o;

   va_entry_t   va_model [N_PAR_VA_RAMS][VA_DEPTH];   // Mirror of the banks
   ppn_t        pa_model [PA_DEPTH];
   tlb_resp_t   exp_resp;
   string       test_name;
   logic        started;
   logic [31:0] seed;

   l2_tlb l2_tlb_inst (.*);

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   initial begin
      #((N_LOOKUPS * LOOKUP_CYCLES + SETUP_CYCLES) * CLK_PERIOD);
      $display("TESTBENCH FAILED");
      $fatal(1, "Watchdog expired, a lookup never completed");
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////
   a_reset_idle : assert property (@(posedge clk_i) (rst_ni && !started) |->
      (!busy_o && !out_valid_o && !resp_o.hit && !resp_o.miss && !resp_o.prot
       && !resp_o.coherent))
      else begin
         $display("CHECK FAILED %s expected idle outputs 0, actual busy %b valid %b resp %h",
                  test_name, busy_o, out_valid_o, resp_o);
         $display("TESTBENCH FAILED");
         $fatal(1);
      end

   a_resp_value : assert property (@(posedge clk_i) disable iff (!rst_ni)
      (out_valid_o && out_ready_i) |-> (resp_o == exp_resp))
      else begin
         $display("CHECK FAILED %s expected %h actual %h", test_name, exp_resp, resp_o);
         $display("TESTBENCH FAILED");
         $fatal(1);
      end

   a_backpressure : assert property (@(posedge clk_i) disable iff (!rst_ni)
      (out_valid_o && !out_ready_i) |=> (out_valid_o && busy_o && $stable(resp_o)))
      else begin
         $display("CHECK FAILED %s expected held response %h actual %h busy %b",
                  test_name, $past(resp_o), resp_o, busy_o);
         $display("TESTBENCH FAILED");
         $fatal(1);
      end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////
   function automatic logic [31:0] next_rand();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   function automatic int entry_idx(input int set, input int grp, input int off);
      return set * 2 * N_OFFSETS + grp * N_OFFSETS + off;
   endfunction

   function automatic vpn_t vpn_in_set(input int set);
      vpn_t v;
      v = vpn_t'(next_rand() >> 5);
      v[SET_W-1:0] = set_idx_t'(set);   // Low VPN bits are the set index
      return v;
   endfunction

   // Expected response by the search order and result rule
   function automatic tlb_resp_t predict(input lookup_req_t r);
      tlb_resp_t t;
      int        set, wb, wa, idx;
      vpn_t      vpn;
      va_entry_t e;
      logic      found, prot, wcoh;
      t     = '0;
      found = 1'b0;
      prot  = 1'b0;
      wcoh  = 1'b0;
      wb    = 0;
      wa    = 0;
      set   = int'(r.vaddr[PAGE_LSB +: SET_W]);
      vpn   = r.vaddr[VADDR_W-1:PAGE_LSB];
      for (int k = 0; k < N_OFFSETS && !found; k++) begin
         for (int b = 0; b < N_PAR_VA_RAMS; b++) begin
            for (int g = 0; g < 2; g++) begin
               idx = entry_idx(set, g, k);
               e   = va_model[b][idx];
               if (e.valid && e.vpn == vpn) begin
                  if (!(r.wr ? e.wr : e.rd)) prot = 1'b1;
                  if (!found) begin   // Lowest bank, then group 0
                     found = 1'b1;
                     wb    = b;
                     wa    = idx;
                     wcoh  = e.coherent;
                  end
               end
            end
         end
      end
      t.hit      = found;
      t.miss     = !found;
      t.prot     = prot;
      t.coherent = found && !prot && wcoh;
      if (found && !prot) begin
         t.paddr = paddr_t'({pa_model[N_PAR_VA_RAMS * wa + wb], r.vaddr[PAGE_LSB-1:0]});
      end
      return t;
   endfunction

   // Drive one write word, caller is at a rising edge
   task automatic drive_va(input int bank, input int idx, input va_entry_t e);
      cfg_addr_t a;
      a = '0;
      a[LL_W-1:0] = bank_idx_t'(bank);
      a[LL_W +: ENTRY_ADDR_W] = entry_addr_t'(idx);
      va_model[bank][idx] = e;
      we_i    <= 1'b1;
      waddr_i <= a;
      wdata_i <= CFG_DATA_W'(e);
   endtask

   task automatic drive_pa(input int idx, input ppn_t p);
      cfg_addr_t a;
      a = '0;
      a[CFG_ADDR_W-1] = 1'b1;
      a[PA_ADDR_W-1:0] = pa_addr_t'(idx);
      pa_model[idx] = p;
      we_i    <= 1'b1;
      waddr_i <= a;
      wdata_i <= CFG_DATA_W'(p);
   endtask

   task automatic place_entry(input int b, input int s, input int g, input int k,
                              input vpn_t vpn, input logic rd, input logic wr,
                              input logic coh);
      va_entry_t e;
      e = '{vpn: vpn, coherent: coh, wr: wr, rd: rd, valid: 1'b1};
      @(posedge clk_i);
      drive_va(b, entry_idx(s, g, k), e);
   endtask

   task automatic run_lookup(input string name, input vpn_t vpn, input logic wr,
                             input logic noise);
      lookup_req_t r;
      va_entry_t   e;
      logic [31:0] rnd;
      logic        wrote;
      int          nset, wait_cyc;
      r.vaddr = {vpn, PAGE_LSB'(next_rand())};
      r.wr    = wr;
      nset    = (int'(vpn[SET_W-1:0]) + 1) % N_SETS;
      wrote   = 1'b0;
      @(posedge clk_i);
      we_i      <= 1'b0;
      test_name = name;
      exp_resp  = predict(r);
      req_i     <= r;
      start_i   <= 1'b1;
      started   <= 1'b1;
      @(posedge clk_i);
      start_i <= 1'b0;
      @(negedge clk_i);
      while (!out_valid_o) begin
         @(posedge clk_i);
         rnd = next_rand();
         if (noise && !wrote && rnd[4]) begin   // At most every other cycle
            wrote = 1'b1;
            if (rnd[5]) begin
               e = '{vpn: vpn_t'(rnd), coherent: rnd[6], wr: rnd[7], rd: rnd[8],
                     valid: rnd[9]};
               drive_va(int'(rnd[10]), entry_idx(nset, int'(rnd[11]), int'(rnd[13:12])), e);
            end else begin
               drive_pa(N_PAR_VA_RAMS * entry_idx(nset, int'(rnd[11]), int'(rnd[13:12]))
                        + int'(rnd[10]), ppn_t'(next_rand()));
            end
         end else begin
            wrote = 1'b0;
            we_i <= 1'b0;
         end
         @(negedge clk_i);
      end
      wait_cyc = int'(next_rand() % (MAX_READY_WAIT + 1));
      @(posedge clk_i);
      we_i <= 1'b0;
      repeat (wait_cyc) @(posedge clk_i);
      out_ready_i <= 1'b1;
      @(posedge clk_i);
      out_ready_i <= 1'b0;
      @(negedge clk_i);
      while (busy_o) @(negedge clk_i);
   endtask

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////
   initial begin
      logic [31:0] rnd;
      vpn_t        v;
      va_entry_t   e;
      int          b, s, g, k;
      seed        = 32'h0df5_9ec1;
      rst_ni      = 1'b0;
      we_i        = 1'b0;
      waddr_i     = '0;
      wdata_i     = '0;
      start_i     = 1'b0;
      req_i       = '0;
      out_ready_i = 1'b0;
      started     = 1'b0;
      exp_resp    = '0;
      test_name   = "reset";
      repeat (3) @(posedge clk_i);
      rst_ni <= 1'b1;
      repeat (4) @(posedge clk_i);

      test_name = "fill";
      for (int bb = 0; bb < N_PAR_VA_RAMS; bb++) begin
         for (int a = 0; a < VA_DEPTH; a++) begin
            rnd = next_rand();
            e = '{vpn: vpn_in_set(a / (2 * N_OFFSETS)), coherent: rnd[3], wr: rnd[2],
                  rd: rnd[1], valid: rnd[0]};
            @(posedge clk_i);
            drive_va(bb, a, e);
         end
      end
      for (int i = 0; i < PA_DEPTH; i++) begin
         @(posedge clk_i);
         drive_pa(i, ppn_t'({next_rand(), 8'(i)}));
      end

      for (int i = 0; i < 6; i++) begin   // Plain hits, permitted access
         rnd = next_rand();
         b = int'(rnd[0]);
         s = int'(rnd[3:1]);
         g = int'(rnd[4]);
         k = int'(rnd[6:5]);
         v = vpn_in_set(s);
         place_entry(b, s, g, k, v, 1'b1, rnd[7], rnd[8]);
         run_lookup("hit", v, rnd[7] & rnd[9], 1'b0);
      end
      for (int i = 0; i < 4; i++) begin
         run_lookup("miss", vpn_in_set(i), 1'b0, 1'b0);
      end

      v = vpn_in_set(2);   // Read-only entry, write access
      place_entry(1, 2, 1, 2, v, 1'b1, 1'b0, 1'b1);
      run_lookup("prot", v, 1'b1, 1'b0);
      v = vpn_in_set(5);   // Permitted and protected in one cycle
      place_entry(0, 5, 0, 1, v, 1'b1, 1'b1, 1'b1);
      place_entry(1, 5, 1, 1, v, 1'b1, 1'b0, 1'b0);
      run_lookup("prot_mixed", v, 1'b1, 1'b0);

      v = vpn_in_set(6);   // Bank 0 group 1 beats bank 1 group 0
      place_entry(1, 6, 0, 3, v, 1'b1, 1'b1, 1'b0);
      place_entry(0, 6, 1, 3, v, 1'b1, 1'b1, 1'b1);
      run_lookup("priority", v, 1'b0, 1'b0);
      v = vpn_in_set(3);   // Group 0 beats group 1 within one bank
      place_entry(1, 3, 1, 0, v, 1'b1, 1'b1, 1'b1);
      place_entry(1, 3, 0, 0, v, 1'b1, 1'b1, 1'b0);
      run_lookup("group_priority", v, 1'b0, 1'b0);

      for (int i = 0; i < 8; i++) begin   // Writes during the search
         rnd = next_rand();
         s = int'(rnd[3:1]);
         v = vpn_in_set(s);
         place_entry(int'(rnd[0]), s, int'(rnd[4]), int'(rnd[6:5]), v, 1'b1, 1'b1, rnd[8]);
         run_lookup("write_during_search", v, rnd[9], 1'b1);
      end

      repeat (2) @(posedge clk_i);
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule
